/* irq_pkg.sv */
// Interrupt controller package

package irq_pkg;

  // One bit per interrupt line, also the APB data width
  typedef logic [31:0] irq_vec_t;

  // Interrupt line number
  typedef logic [4:0]  irq_id_t;

  // Register index, APB address bits 5 to 2
  typedef logic [3:0]  reg_addr_t;

  // APB byte address
  typedef logic [11:0] apb_addr_t;

  // Register map, one word each
  localparam reg_addr_t REG_MASK       = 4'd0; // 0x00
  localparam reg_addr_t REG_MASK_SET   = 4'd1; // 0x04
  localparam reg_addr_t REG_MASK_CLEAR = 4'd2; // 0x08
  localparam reg_addr_t REG_INT        = 4'd3; // 0x0C
  localparam reg_addr_t REG_INT_SET    = 4'd4; // 0x10
  localparam reg_addr_t REG_INT_CLEAR  = 4'd5; // 0x14
  localparam reg_addr_t REG_ACK        = 4'd6; // 0x18
  localparam reg_addr_t REG_ACK_SET    = 4'd7; // 0x1C
  localparam reg_addr_t REG_ACK_CLEAR  = 4'd8; // 0x20
  localparam reg_addr_t REG_FIFO       = 4'd9; // 0x24, last popped event id

  // Defaults for the top level parameters
  localparam int EVT_ID_WIDTH_DEF = 8;
  localparam int FIFO_PIN_DEF     = 26; // Line driven by the event FIFO
  localparam int FIFO_DEPTH_DEF   = 4;

endpackage

/* event_fifo.sv */
// Event id FIFO

`timescale 1ns/10ps

module event_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_valid_i,
  input  logic [DATA_WIDTH-1:0] push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output logic [DATA_WIDTH-1:0] pop_data_o,
  input  logic                  pop_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]      r_wr_ptr;
  logic [PTR_W-1:0]      r_rd_ptr;
  logic [CNT_W-1:0]      r_count;
  logic                  s_push;
  logic                  s_pop;

  assign push_ready_o = (r_count != CNT_W'(DEPTH)); // Low when full
  assign pop_valid_o  = (r_count != '0);
  assign pop_data_o   = mem_q[r_rd_ptr];

  assign s_push = push_valid_i & push_ready_o;
  assign s_pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end
    else
    begin
      if (s_push)
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1; // Wrap
      if (s_pop)
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      case ({s_push, s_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count; // Idle or push and pop together
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (s_push)
      mem_q[r_wr_ptr] <= push_data_i;
  end

endmodule

/* irq_regs.sv */
// Interrupt register block

`timescale 1ns/10ps

module irq_regs #(
  parameter int EVT_ID_WIDTH = 8,
  parameter int FIFO_PIN     = 26
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  irq_pkg::apb_addr_t      paddr_i,
  input  irq_pkg::irq_vec_t       pwdata_i,
  output irq_pkg::irq_vec_t       prdata_o,
  input  irq_pkg::irq_vec_t       events_i,
  input  logic                    fifo_valid_i,
  input  logic [EVT_ID_WIDTH-1:0] fifo_data_i,
  output logic                    fifo_pop_o,
  input  logic                    ack_i,
  input  irq_pkg::irq_id_t        ack_id_i,
  output irq_pkg::irq_vec_t       mask_o,
  output irq_pkg::irq_vec_t       pending_o
);

  import irq_pkg::*;

  irq_vec_t                r_mask;
  irq_vec_t                r_int;
  irq_vec_t                r_ack;
  logic [EVT_ID_WIDTH-1:0] r_fifo_id;

  irq_vec_t                s_mask_next;
  irq_vec_t                s_int_next;
  irq_vec_t                s_ack_next;
  irq_vec_t                s_events;
  irq_vec_t                s_evt_int;
  reg_addr_t               s_reg;
  logic                    s_wr;
  logic                    s_rd;
  logic                    s_ack_fifo;

  assign s_reg = paddr_i[5:2];
  assign s_wr  = psel_i & penable_i & pwrite_i;
  assign s_rd  = psel_i & penable_i & ~pwrite_i;

  assign mask_o    = r_mask;
  assign pending_o = r_int;

  // FIFO level replaces the external pulse on its line
  always_comb
  begin
    s_events           = events_i;
    s_events[FIFO_PIN] = fifo_valid_i;
  end

  assign s_evt_int = r_int | s_events;

  // Pop on core ack of the FIFO line or when software drops its pending bit
  assign s_ack_fifo = ack_i & (ack_id_i == irq_id_t'(FIFO_PIN));
  assign fifo_pop_o = s_ack_fifo |
                      (s_wr & (s_reg == REG_INT_CLEAR) & pwdata_i[FIFO_PIN]) |
                      (s_wr & (s_reg == REG_INT) & ~pwdata_i[FIFO_PIN]);

  always_comb
  begin
    s_mask_next = r_mask;
    if (s_wr)
    begin
      case (s_reg)
        REG_MASK:       s_mask_next = pwdata_i;
        REG_MASK_SET:   s_mask_next = r_mask | pwdata_i;
        REG_MASK_CLEAR: s_mask_next = r_mask & ~pwdata_i;
        default:        s_mask_next = r_mask;
      endcase
    end
  end

  // Ack beats a register write, which beats an event
  always_comb
  begin
    s_int_next = s_evt_int;
    if (s_wr)
    begin
      case (s_reg)
        REG_INT:       s_int_next = pwdata_i; // Events dropped on plain write
        REG_INT_SET:   s_int_next = s_evt_int | pwdata_i;
        REG_INT_CLEAR: s_int_next = s_evt_int & ~pwdata_i;
        default:       s_int_next = s_evt_int;
      endcase
    end
    if (ack_i)
      s_int_next[ack_id_i] = 1'b0;
  end

  always_comb
  begin
    s_ack_next = r_ack;
    if (s_wr)
    begin
      case (s_reg)
        REG_ACK:       s_ack_next = pwdata_i;
        REG_ACK_SET:   s_ack_next = r_ack | pwdata_i;
        REG_ACK_CLEAR: s_ack_next = r_ack & ~pwdata_i;
        default:       s_ack_next = r_ack;
      endcase
    end
    if (ack_i)
      s_ack_next[ack_id_i] = 1'b1;
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      r_mask    <= '0;
      r_int     <= '0;
      r_ack     <= '0;
      r_fifo_id <= '0;
    end
    else
    begin
      r_mask <= s_mask_next;
      r_int  <= s_int_next;
      r_ack  <= s_ack_next;
      if (fifo_pop_o && fifo_valid_i)
        r_fifo_id <= fifo_data_i; // Head leaves the FIFO at this edge
    end
  end

  // Zero outside a read access
  always_comb
  begin
    prdata_o = '0;
    if (s_rd)
    begin
      case (s_reg)
        REG_MASK: prdata_o = r_mask;
        REG_INT:  prdata_o = r_int;
        REG_ACK:  prdata_o = r_ack;
        REG_FIFO: prdata_o = irq_vec_t'(r_fifo_id);
        default:  prdata_o = '0;
      endcase
    end
  end

endmodule

/* irq_id_encoder.sv */
// Interrupt id priority encoder

`timescale 1ns/10ps

module irq_id_encoder (
  input  irq_pkg::irq_vec_t mask_i,
  input  irq_pkg::irq_vec_t pending_i,
  output logic              irq_req_o,
  output irq_pkg::irq_id_t  irq_id_o
);

  import irq_pkg::*;

  irq_vec_t s_active;

  assign s_active  = pending_i & mask_i;
  assign irq_req_o = |s_active;

  // Last hit wins, so the highest index is reported
  always_comb
  begin
    irq_id_o = '0;
    for (int i = 0; i < $bits(irq_vec_t); i++)
    begin
      if (s_active[i])
        irq_id_o = irq_id_t'(i);
    end
  end

endmodule

/* irq_ctrl_top.sv */
// APB interrupt controller top

`timescale 1ns/10ps

module irq_ctrl_top #(
  parameter int EVT_ID_WIDTH = irq_pkg::EVT_ID_WIDTH_DEF,
  parameter int FIFO_PIN     = irq_pkg::FIFO_PIN_DEF,
  parameter int FIFO_DEPTH   = irq_pkg::FIFO_DEPTH_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // APB slave, always zero wait
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  irq_pkg::apb_addr_t      paddr_i,
  input  irq_pkg::irq_vec_t       pwdata_i,
  output irq_pkg::irq_vec_t       prdata_o,
  // Peripheral event ids
  input  logic                    evt_valid_i,
  input  logic [EVT_ID_WIDTH-1:0] evt_data_i,
  output logic                    evt_ready_o,
  input  irq_pkg::irq_vec_t       events_i,
  // Core side
  output logic                    irq_req_o,
  output irq_pkg::irq_id_t        irq_id_o,
  output irq_pkg::irq_vec_t       irq_o,
  input  logic                    irq_ack_i,
  input  irq_pkg::irq_id_t        irq_ack_id_i
);

  import irq_pkg::*;

  logic                    fifo_valid;
  logic [EVT_ID_WIDTH-1:0] fifo_data;
  logic                    fifo_pop;
  irq_vec_t                mask;

  event_fifo #(
    .DATA_WIDTH (EVT_ID_WIDTH),
    .DEPTH      (FIFO_DEPTH)
  ) i_event_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (evt_valid_i),
    .push_data_i  (evt_data_i),
    .push_ready_o (evt_ready_o),
    .pop_valid_o  (fifo_valid),
    .pop_data_o   (fifo_data),
    .pop_ready_i  (fifo_pop)
  );

  irq_regs #(
    .EVT_ID_WIDTH (EVT_ID_WIDTH),
    .FIFO_PIN     (FIFO_PIN)
  ) i_irq_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .events_i     (events_i),
    .fifo_valid_i (fifo_valid),
    .fifo_data_i  (fifo_data),
    .fifo_pop_o   (fifo_pop),
    .ack_i        (irq_ack_i),
    .ack_id_i     (irq_ack_id_i),
    .mask_o       (mask),
    .pending_o    (irq_o)      // Pending vector goes straight out
  );

  irq_id_encoder i_irq_id_encoder (
    .mask_i    (mask),
    .pending_i (irq_o),
    .irq_req_o (irq_req_o),
    .irq_id_o  (irq_id_o)
  );

endmodule

/* irq_ctrl_checker.sv */
// Interrupt controller assertions

`timescale 1ns/10ps

module irq_ctrl_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              irq_req_i,
  input irq_pkg::irq_id_t  irq_id_i,
  input irq_pkg::irq_vec_t pending_i,
  input irq_pkg::irq_vec_t mask_i,
  input logic              evt_valid_i,
  input logic              evt_ready_i,
  input logic              fifo_pop_i
);

  int fail_cnt = 0; // Failed assertions so far

  req_is_or: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_req_i == |(pending_i & mask_i))
  else
  begin
    fail_cnt++;
    $error("irq_req_o differs from the OR of pending and mask");
  end

  // Reported line must be live
  id_is_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_req_i |-> (pending_i[irq_id_i] && mask_i[irq_id_i]))
  else
  begin
    fail_cnt++;
    $error("irq_id_o names a line that is not pending and enabled");
  end

  // A full FIFO stays full unless something is popped
  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (evt_valid_i && !evt_ready_i && !fifo_pop_i) |=> !evt_ready_i)
  else
  begin
    fail_cnt++;
    $error("event push accepted while evt_ready_o was low");
  end

endmodule

bind irq_ctrl_top irq_ctrl_checker i_checker (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .irq_req_i   (irq_req_o),
  .irq_id_i    (irq_id_o),
  .pending_i   (irq_o),
  .mask_i      (mask),
  .evt_valid_i (evt_valid_i),
  .evt_ready_i (evt_ready_o),
  .fifo_pop_i  (fifo_pop)
);

/* tb_irq_ctrl.sv */
// Interrupt controller testbench

`timescale 1ns/10ps

module tb_irq_ctrl;

  import irq_pkg::*;

  localparam int       EVT_W      = EVT_ID_WIDTH_DEF;
  localparam int       FIFO_PIN   = FIFO_PIN_DEF;
  localparam int       FIFO_DEPTH = FIFO_DEPTH_DEF;
  localparam int       PERIOD     = 40;
  localparam irq_vec_t FIFO_BIT   = irq_vec_t'(1) << FIFO_PIN;

  // Row operations
  localparam logic [2:0] OP_WR   = 3'd0;
  localparam logic [2:0] OP_RD   = 3'd1;
  localparam logic [2:0] OP_EVT  = 3'd2;
  localparam logic [2:0] OP_ACK  = 3'd3; // Data column carries events of the same cycle
  localparam logic [2:0] OP_PUSH = 3'd4;
  localparam logic [2:0] OP_IDLE = 3'd5;

  typedef struct packed {
    logic [2:0] op;
    apb_addr_t  addr;      // Byte address or id for acknowledges
    irq_vec_t   data;
    irq_vec_t   exp;       // Expected prdata_o
    irq_vec_t   exp_pend;
    logic       exp_req;
    irq_id_t    exp_id;
    logic       exp_ready;
  } row_t;

  logic              clk_i;
  logic              rst_ni;
  logic              psel_i, penable_i, pwrite_i;
  apb_addr_t         paddr_i;
  irq_vec_t          pwdata_i, prdata_o;
  logic              evt_valid_i, evt_ready_o;
  logic [EVT_W-1:0]  evt_data_i;
  irq_vec_t          events_i, irq_o;
  logic              irq_req_o, irq_ack_i;
  irq_id_t           irq_id_o, irq_ack_id_i;

  // Reference model state
  irq_vec_t          m_mask = '0;
  irq_vec_t          m_int = '0;
  irq_vec_t          m_ack = '0;
  logic [EVT_W-1:0]  m_fifo_id = '0;
  logic [EVT_W-1:0]  m_fifo[$];

  logic [31:0]       lfsr_q = 32'h9517;
  row_t              table_q[$];
  int                vec_errs = 0;
  int                id_errs = 0;
  int                bit_errs = 0;
  int                cycle_limit = 0;

  irq_ctrl_top #(
    .EVT_ID_WIDTH (EVT_W),
    .FIFO_PIN     (FIFO_PIN),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) dut (.*);

  always #(PERIOD / 2) clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic irq_vec_t rand_vec(input int nbits);
    irq_vec_t v;
    v = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]}; // One step per bit
    end
    return v;
  endfunction

  function automatic apb_addr_t byte_addr(input reg_addr_t rg);
    return apb_addr_t'({rg, 2'b00});
  endfunction

  function automatic irq_id_t highest_enabled();
    irq_vec_t act;
    act = m_int & m_mask;
    for (int i = 31; i >= 0; i--)
    begin
      if (act[i])
        return irq_id_t'(i);
    end
    return '0;
  endfunction

  // One rising edge of the model
  task automatic step_model(input logic wr = 1'b0, input reg_addr_t rg = '0,
                            input irq_vec_t wdata = '0, input irq_vec_t evt = '0,
                            input logic ack = 1'b0, input irq_id_t ack_id = '0,
                            input logic push = 1'b0, input logic [EVT_W-1:0] pdata = '0);
    irq_vec_t nxt;
    logic     pop;
    logic     ready;
    ready         = (m_fifo.size() < FIFO_DEPTH);
    evt[FIFO_PIN] = (m_fifo.size() != 0); // FIFO level owns this line
    pop = (ack && ack_id == irq_id_t'(FIFO_PIN)) ||
          (wr && rg == REG_INT_CLEAR && wdata[FIFO_PIN]) ||
          (wr && rg == REG_INT && !wdata[FIFO_PIN]);
    nxt = m_int | evt;
    if (wr)
    begin
      case (rg)
        REG_MASK:       m_mask = wdata;
        REG_MASK_SET:   m_mask = m_mask | wdata;
        REG_MASK_CLEAR: m_mask = m_mask & ~wdata;
        REG_INT:        nxt = wdata;
        REG_INT_SET:    nxt = nxt | wdata;
        REG_INT_CLEAR:  nxt = nxt & ~wdata;
        REG_ACK:        m_ack = wdata;
        REG_ACK_SET:    m_ack = m_ack | wdata;
        REG_ACK_CLEAR:  m_ack = m_ack & ~wdata;
        default:        ;
      endcase
    end
    if (ack)
    begin
      nxt[ack_id]   = 1'b0; // Ack wins over write and event
      m_ack[ack_id] = 1'b1;
    end
    m_int = nxt;
    if (pop && m_fifo.size() != 0)
      m_fifo_id = m_fifo.pop_front();
    if (push && ready)
      m_fifo.push_back(pdata);
  endtask

  task automatic add_row(input logic [2:0] op, input apb_addr_t addr, input irq_vec_t data);
    row_t r;
    r      = '0;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    case (op)
      OP_WR:
      begin
        step_model(); // Setup phase
        step_model(1'b1, addr[5:2], data);
      end
      OP_RD:
      begin
        step_model();
        case (addr[5:2])
          REG_MASK: r.exp = m_mask;
          REG_INT:  r.exp = m_int;
          REG_ACK:  r.exp = m_ack;
          REG_FIFO: r.exp = irq_vec_t'(m_fifo_id);
          default:  r.exp = '0;
        endcase
        step_model();
      end
      OP_EVT:  step_model(1'b0, '0, '0, data);
      OP_ACK:  step_model(1'b0, '0, '0, data, 1'b1, addr[4:0]);
      OP_PUSH: step_model(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, data[EVT_W-1:0]);
      default: step_model();
    endcase
    r.exp_pend  = m_int;
    r.exp_req   = |(m_int & m_mask);
    r.exp_id    = highest_enabled();
    r.exp_ready = (m_fifo.size() < FIFO_DEPTH);
    table_q.push_back(r);
  endtask

  task automatic build_table();
    // Reset values
    add_row(OP_RD, byte_addr(REG_MASK), '0);
    add_row(OP_RD, byte_addr(REG_INT), '0);
    add_row(OP_RD, byte_addr(REG_ACK), '0);
    add_row(OP_RD, byte_addr(REG_FIFO), '0);
    // Indices 0 to 8 are plain, set and clear for each register
    for (int r = 0; r < 9; r++)
    begin
      add_row(OP_WR, byte_addr(reg_addr_t'(r)), rand_vec(32));
      add_row(OP_RD, byte_addr(reg_addr_t'(r - r % 3)), '0);
    end
    add_row(OP_WR, byte_addr(REG_INT), '0);
    add_row(OP_WR, byte_addr(REG_ACK), '0);
    add_row(OP_WR, byte_addr(REG_MASK), rand_vec(32) & ~FIFO_BIT);
    for (int i = 0; i < 10; i++)
    begin
      add_row(OP_EVT, '0, rand_vec(32) & rand_vec(32) & rand_vec(32)); // Sparse pulses
      if (i % 4 == 3)
        add_row(OP_WR, byte_addr(REG_INT), '0);
    end
    for (int i = 0; i < 3; i++)
      add_row(OP_ACK, apb_addr_t'(highest_enabled()), '0);
    add_row(OP_ACK, apb_addr_t'(7), irq_vec_t'(1) << 7); // Event and ack on one line
    add_row(OP_RD, byte_addr(REG_INT), '0);
    add_row(OP_RD, byte_addr(REG_ACK), '0);
    // FIFO fill where the last push is refused
    add_row(OP_WR, byte_addr(REG_INT), '0);
    add_row(OP_WR, byte_addr(REG_MASK_SET), FIFO_BIT);
    for (int i = 0; i <= FIFO_DEPTH; i++)
      add_row(OP_PUSH, '0, rand_vec(EVT_W));
    add_row(OP_IDLE, '0, '0);
    for (int i = 0; i < 2; i++)
    begin
      add_row(OP_ACK, apb_addr_t'(FIFO_PIN), '0);
      add_row(OP_RD, byte_addr(REG_FIFO), '0);
    end
    // Third clear finds the FIFO empty
    for (int i = 0; i < 3; i++)
    begin
      add_row(OP_WR, byte_addr(REG_INT_CLEAR), FIFO_BIT);
      add_row(OP_RD, byte_addr(REG_FIFO), '0);
    end
    add_row(OP_IDLE, '0, '0);
    add_row(OP_IDLE, '0, '0);
    add_row(OP_RD, byte_addr(REG_INT), '0);
  endtask

  task automatic drive_idle();
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    evt_valid_i  = 1'b0;
    evt_data_i   = '0;
    events_i     = '0;
    irq_ack_i    = 1'b0;
    irq_ack_id_i = '0;
  endtask

  task automatic vec_check(input irq_vec_t got, input irq_vec_t exp, input string what);
    if (got !== exp)
    begin
      vec_errs++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic id_check(input irq_id_t got, input irq_id_t exp, input string what);
    if (got !== exp)
    begin
      id_errs++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic bit_check(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      bit_errs++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic apply_row(input row_t r, input int idx);
    string tag;
    tag = $sformatf("row %0d", idx);
    @(negedge clk_i);
    drive_idle();
    case (r.op)
      OP_WR, OP_RD:
      begin
        psel_i   = 1'b1;
        pwrite_i = (r.op == OP_WR);
        paddr_i  = r.addr;
        pwdata_i = r.data;
        @(negedge clk_i);
        penable_i = 1'b1; // Access phase
      end
      OP_EVT:  events_i = r.data;
      OP_ACK:
      begin
        irq_ack_i    = 1'b1;
        irq_ack_id_i = r.addr[4:0];
        events_i     = r.data;
      end
      OP_PUSH:
      begin
        evt_valid_i = 1'b1;
        evt_data_i  = r.data[EVT_W-1:0];
      end
      default: ;
    endcase
    #(PERIOD / 4);
    vec_check(prdata_o, r.exp, {tag, " prdata_o"}); // Zero unless reading
    @(posedge clk_i);
    #(PERIOD / 4); // Registers settled
    vec_check(irq_o, r.exp_pend, {tag, " irq_o"});
    bit_check(irq_req_o, r.exp_req, {tag, " irq_req_o"});
    id_check(irq_id_o, r.exp_id, {tag, " irq_id_o"});
    bit_check(evt_ready_o, r.exp_ready, {tag, " evt_ready_o"});
  endtask

  // Run limit
  initial
  begin
    int cycles;
    cycles = 0;
    wait (cycle_limit != 0);
    while (cycles < cycle_limit)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the stimulus table did not finish within %0d cycles", cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int total;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    drive_idle();
    build_table();
    cycle_limit = table_q.size() * 4 + 50;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (table_q[i])
      apply_row(table_q[i], i);
    @(negedge clk_i);
    drive_idle();
    @(negedge clk_i);
    total = vec_errs + id_errs + bit_errs + dut.i_checker.fail_cnt;
    $display("Errors: vector %0d, id %0d, bit %0d, assertion %0d",
             vec_errs, id_errs, bit_errs, dut.i_checker.fail_cnt);
    if (total == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* flist.f */
irq_pkg.sv
event_fifo.sv
irq_regs.sv
irq_id_encoder.sv
irq_ctrl_top.sv
irq_ctrl_checker.sv
tb_irq_ctrl.sv

/* Makefile */
# Verilator flow for the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= tb_irq_ctrl
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
